/* verilog/sa_pkg.sv */
package sa_pkg;

    //////////////////////////////
    // Array and buffer sizes
    //////////////////////////////

    localparam int array_dim    = 2;
    localparam int data_bits    = 8;
    localparam int acc_bits     = 24;
    localparam int addr_bits    = 4;
    localparam int buf_depth    = 1 << addr_bits;
    localparam int row_sel_bits = $clog2(array_dim);

    //////////////////////////////
    // Instruction format
    //////////////////////////////

    // Codes not listed decode as nop
    typedef enum logic [3:0] {
        op_nop          = 4'h0,
        op_write_data   = 4'h1,
        op_write_weight = 4'h2,
        op_load_weight  = 4'h3,
        op_mat_mul      = 4'h4,
        op_mat_mul_acc  = 4'h5,
        op_read_result  = 4'h6
    } opcode_t;

    typedef logic signed [data_bits-1:0] data_t;
    typedef logic signed [acc_bits-1:0]  acc_t;

    // One vector across the array, element 0 in the low bits
    typedef data_t [array_dim-1:0] row_t;
    typedef acc_t  [array_dim-1:0] acc_row_t;

    typedef struct packed {
        opcode_t              opcode;
        logic [addr_bits-1:0] addr_a;
        logic [addr_bits-1:0] addr_b;
        logic [3:0]           operand;
        row_t                 data;
    } instr_t;

    //////////////////////////////
    // Datapath enables
    //////////////////////////////

    typedef struct packed {
        logic                    read_ub;
        logic                    write_ub;
        logic                    read_wb;
        logic                    write_wb;
        logic                    load_weight;
        logic                    mm_en;
        logic                    acc_en;
        logic                    acc_add;
        logic                    read_acc;
        logic [addr_bits-1:0]    addr_a;
        logic [addr_bits-1:0]    addr_b;
        logic [row_sel_bits-1:0] weight_row;
    } ctrl_t;

endpackage

/* verilog/buffer_ram.sv */
`timescale 1ns/1ps

module buffer_ram #(
    parameter type word_t = sa_pkg::row_t,
    parameter int  depth  = sa_pkg::buf_depth
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [sa_pkg::addr_bits-1:0] waddr,
    input  word_t                        wdata,
    input  logic                         re,
    input  logic [sa_pkg::addr_bits-1:0] raddr,
    output word_t                        rdata
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, output holds between reads
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    assert property (@(posedge clk) we |-> int'(waddr) < depth);

    assert property (@(posedge clk) re |-> int'(raddr) < depth);

endmodule

/* verilog/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic             clk,
    input  logic             reset_n,
    input  sa_pkg::instr_t   instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  sa_pkg::acc_row_t acc_rdata,
    output sa_pkg::acc_row_t result,
    output logic             result_valid,
    input  logic             result_ready,
    output sa_pkg::ctrl_t    ctrl,
    output sa_pkg::row_t     wr_row
);

    sa_pkg::opcode_t               opcode;
    logic [1:0]                    minor_state;
    logic [sa_pkg::addr_bits-1:0]  addr_a;
    logic [sa_pkg::addr_bits-1:0]  addr_b;
    sa_pkg::acc_row_t              result_q;
    logic                          accept;
    logic                          last_phase;

    assign accept = instr_valid && instr_ready;

    // Opcode and minor state
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            opcode      <= sa_pkg::op_nop;
            minor_state <= 2'd0;
        end else if (accept) begin
            opcode      <= instr.opcode;
            minor_state <= 2'd0;
        end else if (last_phase) begin
            opcode      <= sa_pkg::op_nop;
            minor_state <= 2'd0;
        end else if (minor_state != 2'd2) begin
            // Read result parks in phase 2 while the host stalls
            minor_state <= minor_state + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_a <= instr.addr_a;
            addr_b <= instr.addr_b;
            wr_row <= instr.data;
        end
        if (result_valid && minor_state == 2'd1) begin
            result_q <= acc_rdata;
        end
    end

    // First valid cycle passes the RAM output, later cycles the held copy
    assign result = (minor_state == 2'd1) ? acc_rdata : result_q;

    //////////////////////////////
    // Enables per phase
    //////////////////////////////

    always_comb begin
        ctrl            = '0;
        ctrl.addr_a     = addr_a;
        ctrl.addr_b     = addr_b;
        ctrl.weight_row = addr_b[sa_pkg::row_sel_bits-1:0];
        instr_ready     = 1'b0;
        result_valid    = 1'b0;
        last_phase      = 1'b0;
        case (opcode)
            sa_pkg::op_write_data: begin
                ctrl.write_ub = 1'b1;
                instr_ready   = 1'b1;
                last_phase    = 1'b1;
            end
            sa_pkg::op_write_weight: begin
                ctrl.write_wb = 1'b1;
                instr_ready   = 1'b1;
                last_phase    = 1'b1;
            end
            sa_pkg::op_load_weight: begin
                if (minor_state == 2'd0) begin
                    ctrl.read_wb = 1'b1;
                end else begin
                    ctrl.load_weight = 1'b1;
                    last_phase       = 1'b1;
                end
            end
            sa_pkg::op_mat_mul, sa_pkg::op_mat_mul_acc: begin
                case (minor_state)
                    2'd0: ctrl.read_ub = 1'b1;
                    2'd1: ctrl.mm_en   = 1'b1;
                    default: begin
                        ctrl.acc_en  = 1'b1;
                        ctrl.acc_add = (opcode == sa_pkg::op_mat_mul_acc);
                        last_phase   = 1'b1;
                    end
                endcase
            end
            sa_pkg::op_read_result: begin
                if (minor_state == 2'd0) begin
                    ctrl.read_acc = 1'b1;
                end else begin
                    result_valid = 1'b1;
                    last_phase   = result_ready;
                end
            end
            default: begin
                // nop and unused codes
                instr_ready = 1'b1;
                last_phase  = 1'b1;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({ctrl.read_ub, ctrl.read_wb, ctrl.read_acc}));

    assert property (@(posedge clk) disable iff (!reset_n)
        !(instr_ready && result_valid));

    assert property (@(posedge clk) disable iff (!reset_n)
        result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

/* verilog/systolic_array.sv */
`timescale 1ns/1ps

module systolic_array (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            load_weight,
    input  logic [sa_pkg::row_sel_bits-1:0] weight_row,
    input  sa_pkg::row_t                    weight_in,
    input  logic                            mm_en,
    input  sa_pkg::row_t                    x_in,
    output sa_pkg::acc_row_t                prod,
    output logic                            prod_valid
);

    // Stationary weights, one row_t per array row
    sa_pkg::row_t     weight [sa_pkg::array_dim];
    sa_pkg::acc_row_t col_sum;

    always_ff @(posedge clk) begin
        if (load_weight) begin
            weight[weight_row] <= weight_in;
        end
    end

    //////////////////////////////
    // Cell grid
    //////////////////////////////

    for (genvar c = 0; c < sa_pkg::array_dim; c++) begin : g_col
        logic signed [sa_pkg::acc_bits-1:0] psum [sa_pkg::array_dim];

        for (genvar r = 0; r < sa_pkg::array_dim; r++) begin : g_cell
            logic signed [sa_pkg::acc_bits-1:0] mac;

            // Input element r runs along row r
            assign mac = $signed(x_in[r]) * $signed(weight[r][c]);

            if (r == 0) begin : g_top
                assign psum[r] = mac;
            end else begin : g_inner
                // Partial sum flows down from the cell above
                assign psum[r] = psum[r-1] + mac;
            end
        end

        assign col_sum[c] = psum[sa_pkg::array_dim-1];
    end

    always_ff @(posedge clk) begin
        if (mm_en) begin
            prod <= col_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= mm_en;
        end
    end

    // A weight change mid-multiply would mix old and new rows
    assert property (@(posedge clk) disable iff (!reset_n)
        !(mm_en && load_weight));

endmodule

/* verilog/accumulator.sv */
`timescale 1ns/1ps

module accumulator (
    input  logic                         clk,
    input  logic                         acc_en,
    input  logic                         acc_add,
    input  logic [sa_pkg::addr_bits-1:0] waddr,
    input  sa_pkg::acc_row_t             prod,
    input  logic                         read_acc,
    input  logic [sa_pkg::addr_bits-1:0] raddr,
    output sa_pkg::acc_row_t             rdata
);

    // Shadow copy gives the old row in the write cycle
    sa_pkg::acc_row_t shadow [sa_pkg::buf_depth];
    sa_pkg::acc_row_t old_row;
    sa_pkg::acc_row_t wdata;

    assign old_row = shadow[waddr];

    always_comb begin
        for (int c = 0; c < sa_pkg::array_dim; c++) begin
            // Wraps at acc_bits
            wdata[c] = acc_add ? old_row[c] + prod[c] : prod[c];
        end
    end

    always_ff @(posedge clk) begin
        if (acc_en) begin
            shadow[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // Readable store
    //////////////////////////////

    buffer_ram #(
        .word_t (sa_pkg::acc_row_t),
        .depth  (sa_pkg::buf_depth)
    ) u_store (
        .clk   (clk),
        .we    (acc_en),
        .waddr (waddr),
        .wdata (wdata),
        .re    (read_acc),
        .raddr (raddr),
        .rdata (rdata)
    );

endmodule

/* verilog/sa_top.sv */
`timescale 1ns/1ps

module sa_top (
    input  logic             clk,
    input  logic             reset_n,
    input  sa_pkg::instr_t   instr,
    input  logic             instr_valid,
    output logic             instr_ready,
    output sa_pkg::acc_row_t result,
    output logic             result_valid,
    input  logic             result_ready
);

    sa_pkg::ctrl_t    ctrl;
    sa_pkg::row_t     wr_row;
    sa_pkg::row_t     ub_rdata;
    sa_pkg::row_t     wb_rdata;
    sa_pkg::acc_row_t prod;
    logic             prod_valid;
    sa_pkg::acc_row_t acc_rdata;

    control_unit u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .acc_rdata    (acc_rdata),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .ctrl         (ctrl),
        .wr_row       (wr_row)
    );

    //////////////////////////////
    // Unified and weight buffers
    //////////////////////////////

    buffer_ram #(.word_t(sa_pkg::row_t), .depth(sa_pkg::buf_depth)) ub (
        .clk   (clk),
        .we    (ctrl.write_ub),
        .waddr (ctrl.addr_b),
        .wdata (wr_row),
        .re    (ctrl.read_ub),
        .raddr (ctrl.addr_a),
        .rdata (ub_rdata)
    );

    buffer_ram #(.word_t(sa_pkg::row_t), .depth(sa_pkg::buf_depth)) wb (
        .clk   (clk),
        .we    (ctrl.write_wb),
        .waddr (ctrl.addr_b),
        .wdata (wr_row),
        .re    (ctrl.read_wb),
        .raddr (ctrl.addr_a),
        .rdata (wb_rdata)
    );

    systolic_array u_array (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_weight (ctrl.load_weight),
        .weight_row  (ctrl.weight_row),
        .weight_in   (wb_rdata),
        .mm_en       (ctrl.mm_en),
        .x_in        (ub_rdata),
        .prod        (prod),
        .prod_valid  (prod_valid)
    );

    accumulator u_acc (
        .clk      (clk),
        .acc_en   (ctrl.acc_en),
        .acc_add  (ctrl.acc_add),
        .waddr    (ctrl.addr_b),
        .prod     (prod),
        .read_acc (ctrl.read_acc),
        .raddr    (ctrl.addr_a),
        .rdata    (acc_rdata)
    );

    // Controller phase count must line up with the array latency
    assert property (@(posedge clk) disable iff (!reset_n)
        ctrl.acc_en |-> prod_valid);

endmodule

/* verif/sa_tb.sv */
`timescale 1ns/1ps

module sa_tb;

    localparam int          check_w        = $bits(sa_pkg::acc_row_t);
    localparam int          timeout_cycles = 100;
    localparam logic [31:0] seed           = 32'h7f48_b4fc;

    logic             clk;
    logic             reset_n;
    sa_pkg::instr_t   instr;
    logic             instr_valid;
    logic             instr_ready;
    sa_pkg::acc_row_t result;
    logic             result_valid;
    logic             result_ready;

    // Model state
    sa_pkg::row_t     ub_model  [sa_pkg::buf_depth];
    sa_pkg::row_t     wb_model  [sa_pkg::buf_depth];
    sa_pkg::row_t     w_model   [sa_pkg::array_dim];
    sa_pkg::acc_row_t acc_model [sa_pkg::buf_depth];
    sa_pkg::acc_row_t expect_q  [$];

    sa_top DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Helpers and reference model
    //////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Vector times weight grid, optionally added to the old row
    function automatic sa_pkg::acc_row_t ref_mat_mul(sa_pkg::row_t x, logic add,
                                                     sa_pkg::acc_row_t old);
        sa_pkg::acc_row_t res;
        sa_pkg::acc_t     sum;
        for (int c = 0; c < sa_pkg::array_dim; c++) begin
            sum = add ? old[c] : '0;
            for (int r = 0; r < sa_pkg::array_dim; r++) begin
                sum = sum + sa_pkg::acc_t'(x[r]) * sa_pkg::acc_t'(w_model[r][c]);
            end
            res[c] = sum;
        end
        return res;
    endfunction

    function automatic sa_pkg::row_t make_row(int e0, int e1);
        sa_pkg::row_t row;
        row[0] = sa_pkg::data_t'(e0);
        row[1] = sa_pkg::data_t'(e1);
        return row;
    endfunction

    function automatic sa_pkg::instr_t pack_instr(sa_pkg::opcode_t op, logic [3:0] a,
                                                  logic [3:0] b, sa_pkg::row_t d);
        sa_pkg::instr_t ins;
        ins.opcode  = op;
        ins.addr_a  = a;
        ins.addr_b  = b;
        ins.operand = 4'd0;
        ins.data    = d;
        return ins;
    endfunction

    task automatic stop_run(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [check_w-1:0] got,
                               logic [check_w-1:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // Model follows each accepted instruction
    task automatic update_model(sa_pkg::instr_t ins);
        case (ins.opcode)
            sa_pkg::op_write_data:   ub_model[ins.addr_b] = ins.data;
            sa_pkg::op_write_weight: wb_model[ins.addr_b] = ins.data;
            sa_pkg::op_load_weight:
                w_model[int'(ins.addr_b) % sa_pkg::array_dim] = wb_model[ins.addr_a];
            sa_pkg::op_mat_mul:
                acc_model[ins.addr_b] = ref_mat_mul(ub_model[ins.addr_a], 1'b0,
                                                    acc_model[ins.addr_b]);
            sa_pkg::op_mat_mul_acc:
                acc_model[ins.addr_b] = ref_mat_mul(ub_model[ins.addr_a], 1'b1,
                                                    acc_model[ins.addr_b]);
            sa_pkg::op_read_result:  expect_q.push_back(acc_model[ins.addr_a]);
            default: ;
        endcase
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic issue_instr(sa_pkg::instr_t ins);
        int waited;
        waited = 0;
        instr       = ins;
        instr_valid = 1'b1;
        while (!instr_ready) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                stop_run("timeout waiting for instr_ready");
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        update_model(ins);
    endtask

    //////////////////////////////
    // Result comparison
    //////////////////////////////

    initial begin : result_checker
        sa_pkg::acc_row_t held;
        sa_pkg::acc_row_t want;
        logic [31:0]      stall_rng;
        int               stall;
        int               idle;
        result_ready = 1'b0;
        stall_rng    = seed ^ 32'h5bd1_e995;
        idle         = 0;
        forever begin
            @(negedge clk);
            if (reset_n && result_valid) begin
                if (expect_q.size() == 0) begin
                    stop_run("result_valid rose with no read pending");
                end else begin
                    want      = expect_q[0];
                    held      = result;
                    stall_rng = xorshift32(stall_rng);
                    stall     = int'(stall_rng[2:0]);
                    // Hold ready low for a random stretch
                    for (int i = 0; i < stall; i++) begin
                        @(negedge clk);
                        check_value("result_valid under stall", check_w'(result_valid),
                                    check_w'(1'b1));
                        check_value("instr_ready under stall", check_w'(instr_ready),
                                    check_w'(1'b0));
                        check_value("result held under stall", result, held);
                    end
                    check_value("result row", result, want);
                    result_ready = 1'b1;
                    expect_q.delete(0);
                    @(negedge clk);
                    result_ready = 1'b0;
                    idle = 0;
                end
            end else if (expect_q.size() != 0) begin
                idle++;
                if (idle > timeout_cycles) begin
                    stop_run("timeout waiting for result_valid");
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        sa_pkg::instr_t ins;
        logic [31:0]    rng;
        logic [3:0]     code;
        int             waited;
        instr       = '0;
        instr_valid = 1'b0;
        reset_n     = 1'b0;
        rng         = seed;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("instr_ready after reset", check_w'(instr_ready), check_w'(1'b1));
        check_value("result_valid after reset", check_w'(result_valid), check_w'(1'b0));

        // Basic product
        issue_instr(pack_instr(sa_pkg::op_write_data, 4'd0, 4'd0, make_row(3, -2)));
        issue_instr(pack_instr(sa_pkg::op_write_data, 4'd0, 4'd1, make_row(-128, 127)));
        issue_instr(pack_instr(sa_pkg::op_write_weight, 4'd0, 4'd2, make_row(4, -5)));
        issue_instr(pack_instr(sa_pkg::op_write_weight, 4'd0, 4'd3, make_row(-7, 6)));
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd2, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd3, 4'd1, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd0, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd0, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd1, 4'd1, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd1, 4'd0, '0));

        // Accumulate into one row, then overwrite it
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd0, 4'd5, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul_acc, 4'd1, 4'd5, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul_acc, 4'd0, 4'd5, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd5, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd1, 4'd5, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd5, 4'd0, '0));

        // Nop and unused codes leave all state alone
        issue_instr(pack_instr(sa_pkg::op_nop, 4'd1, 4'd0, make_row(9, 9)));
        for (int c = 7; c < 16; c++) begin
            issue_instr(pack_instr(sa_pkg::opcode_t'(4'(c)), 4'(c), 4'(c - 7),
                                   make_row(c, -c)));
        end
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd0, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd5, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd1, 4'd2, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd2, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd2, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd3, 4'd1, '0));
        issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'd0, 4'd3, '0));
        issue_instr(pack_instr(sa_pkg::op_read_result, 4'd3, 4'd0, '0));

        // Fill every row so random reads see known data
        for (int i = 0; i < sa_pkg::buf_depth; i++) begin
            rng = xorshift32(rng);
            issue_instr(pack_instr(sa_pkg::op_write_data, 4'd0, 4'(i), rng[15:0]));
            issue_instr(pack_instr(sa_pkg::op_write_weight, 4'd0, 4'(i), rng[31:16]));
        end
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd4, 4'd0, '0));
        issue_instr(pack_instr(sa_pkg::op_load_weight, 4'd9, 4'd1, '0));
        for (int i = 0; i < sa_pkg::buf_depth; i++) begin
            issue_instr(pack_instr(sa_pkg::op_mat_mul, 4'(i), 4'(i), '0));
        end

        // Random mix, unused codes now and then
        for (int n = 0; n < 300; n++) begin
            rng  = xorshift32(rng);
            code = (rng[31:29] == 3'b000) ? rng[3:0] : {1'b0, rng[2:0]};
            rng  = xorshift32(rng);
            ins.opcode  = sa_pkg::opcode_t'(code);
            ins.addr_a  = rng[3:0];
            ins.addr_b  = rng[7:4];
            ins.operand = rng[11:8];
            ins.data    = rng[31:16];
            issue_instr(ins);
        end

        waited = 0;
        while (expect_q.size() != 0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout waiting for the last results to be read");
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* sources.f */
verilog/sa_pkg.sv
verilog/buffer_ram.sv
verilog/control_unit.sv
verilog/systolic_array.sv
verilog/accumulator.sv
verilog/sa_top.sv
verif/sa_tb.sv

/* Makefile */
TOP := sa_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
